//--- logic/l2_cache_pkg.sv
package l2_cache_pkg;

    // geometry of the second-level cache
    // two ways of eight sets, 32-byte lines

    // byte address width seen on both ports
    localparam int l2_addr_bits = 32;

    // byte offset inside one line
    localparam int l2_offset_bits = 5;

    // set index, eight sets
    localparam int l2_index_bits = 3;

    // everything above index and offset
    localparam int l2_tag_bits = l2_addr_bits - l2_index_bits - l2_offset_bits;

    // whole line as traded with the upstream cache
    localparam int l2_line_bits = 256;

    // entries per way
    localparam int l2_num_sets = 1 << l2_index_bits;

    // byte address on upstream and downstream ports
    typedef logic [l2_addr_bits-1:0] l2_addr_t;

    // stored tag
    typedef logic [l2_tag_bits-1:0] l2_tag_t;

    // set select
    typedef logic [l2_index_bits-1:0] l2_index_t;

    // one cache line of data
    typedef logic [l2_line_bits-1:0] l2_line_t;

endpackage

//--- logic/l2_way.sv
`timescale 1ns/100ps

module l2_way (
    input  logic                    clk,
    input  logic                    rst_n,
    // addressed set and compare tag
    input  l2_cache_pkg::l2_index_t index,
    input  l2_cache_pkg::l2_tag_t   tag,
    // write strobes for the addressed set
    input  logic                    load_line,
    input  logic                    load_valid,
    input  logic                    load_dirty,
    input  logic                    valid_in,
    input  logic                    dirty_in,
    input  l2_cache_pkg::l2_line_t  line_in,
    // lookup results
    output logic                    way_hit,
    output logic                    way_dirty,
    output l2_cache_pkg::l2_tag_t   way_tag,
    output l2_cache_pkg::l2_line_t  way_line
);

    import l2_cache_pkg::*;

    // storage for each set
    l2_tag_t                tag_arr  [l2_num_sets];
    l2_line_t               line_arr [l2_num_sets];
    logic [l2_num_sets-1:0] valid_arr;
    logic [l2_num_sets-1:0] dirty_arr;

    // valid and dirty cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            if (load_valid) begin
                valid_arr[index] <= valid_in;
            end
            if (load_dirty) begin
                dirty_arr[index] <= dirty_in;
            end
        end
    end

    // tag goes in with the line
    always_ff @(posedge clk) begin
        if (load_line) begin
            tag_arr[index]  <= tag;
            line_arr[index] <= line_in;
        end
    end

    // combinational read of the addressed entry
    assign way_tag   = tag_arr[index];
    assign way_line  = line_arr[index];
    assign way_dirty = dirty_arr[index];

    // valid folded into the compare
    assign way_hit = valid_arr[index] && (tag_arr[index] == tag);

endmodule

//--- logic/l2_cache_control.sv
`timescale 1ns/100ps

module l2_cache_control (
    input  logic clk,
    input  logic rst_n,
    // upstream request levels
    input  logic mem_read,
    input  logic mem_write,
    output logic mem_resp,
    // physical memory strobes
    output logic pmem_read,
    output logic pmem_write,
    input  logic pmem_resp,
    // status from the datapath
    input  logic hit,
    input  logic dirty,
    // datapath control
    output logic load_line_data,
    output logic load_valid,
    output logic load_dirty,
    output logic load_lru,
    output logic line_datain_sel,
    output logic valid_in,
    output logic dirty_in,
    output logic way_sel_method,
    output logic address_sel,
    // miss indicator
    output logic if_miss
);

    typedef enum logic [2:0] {
        idle,
        ready,
        write_back,
        read_mem,
        read_mem2
    } l2_state_t;

    l2_state_t state;
    l2_state_t next_state;

    // per-state output decode
    always_comb begin
        // everything off unless a state asks for it
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        load_line_data  = 1'b0;
        load_valid      = 1'b0;
        load_dirty      = 1'b0;
        load_lru        = 1'b0;
        line_datain_sel = 1'b0;
        valid_in        = 1'b0;
        dirty_in        = 1'b0;
        way_sel_method  = 1'b0;
        address_sel     = 1'b0;
        if_miss         = 1'b0;
        case (state)
            ready: begin
                // hit path on the hit way
                mem_resp        = hit && (mem_read || mem_write);
                load_lru        = hit;
                // write hit stores upstream data and marks the line dirty
                line_datain_sel = 1'b1;
                load_line_data  = hit && mem_write;
                load_dirty      = hit && mem_write;
                dirty_in        = 1'b1;
            end
            write_back: begin
                // victim line out to memory at the victim address
                way_sel_method = 1'b1;
                address_sel    = 1'b1;
                pmem_write     = 1'b1;
                if_miss        = 1'b1;
            end
            read_mem: begin
                // fetch the requested line into the victim way
                way_sel_method = 1'b1;
                pmem_read      = 1'b1;
                // data and tag captured while pmem_rdata is valid
                load_line_data = pmem_resp;
            end
            read_mem2: begin
                // new line becomes valid and clean
                way_sel_method = 1'b1;
                load_valid     = 1'b1;
                valid_in       = 1'b1;
                load_dirty     = 1'b1;
                dirty_in       = 1'b0;
                if_miss        = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // transitions
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (mem_read || mem_write) begin
                    next_state = ready;
                end
            end
            ready: begin
                // a hit finishes and a miss evicts or fills
                if (hit) begin
                    next_state = idle;
                end else if (dirty) begin
                    next_state = write_back;
                end else begin
                    next_state = read_mem;
                end
            end
            write_back: begin
                if (pmem_resp) begin
                    next_state = read_mem;
                end
            end
            read_mem: begin
                if (pmem_resp) begin
                    next_state = read_mem2;
                end
            end
            read_mem2: begin
                // retry the request so that it hits
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // a response only follows a request already held one cycle earlier
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |-> $past(mem_read || mem_write));

    // a memory strobe keeps its direction until pmem_resp
    assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_read || pmem_write) && !pmem_resp |=> $stable({pmem_read, pmem_write}));

endmodule

//--- logic/l2_datapath.sv
`timescale 1ns/100ps

module l2_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    // upstream side
    input  l2_cache_pkg::l2_addr_t mem_address,
    input  l2_cache_pkg::l2_line_t mem_wdata,
    output l2_cache_pkg::l2_line_t mem_rdata,
    // downstream side
    input  l2_cache_pkg::l2_line_t pmem_rdata,
    output l2_cache_pkg::l2_line_t pmem_wdata,
    output l2_cache_pkg::l2_addr_t pmem_address,
    // control strobes
    input  logic                   load_line_data,
    input  logic                   load_valid,
    input  logic                   load_dirty,
    input  logic                   load_lru,
    input  logic                   line_datain_sel,
    input  logic                   valid_in,
    input  logic                   dirty_in,
    input  logic                   way_sel_method,
    input  logic                   address_sel,
    // status back to control
    output logic                   hit,
    output logic                   dirty
);

    import l2_cache_pkg::*;

    l2_index_t              index;
    l2_tag_t                tag;
    l2_line_t               line_in;
    logic [l2_num_sets-1:0] lru_bits;
    logic                   victim;
    logic                   sel_way;
    logic                   way0_hit;
    logic                   way1_hit;
    logic                   way0_dirty;
    logic                   way1_dirty;
    l2_tag_t                way0_tag;
    l2_tag_t                way1_tag;
    l2_line_t               way0_line;
    l2_line_t               way1_line;

    // address split
    assign index = mem_address[l2_offset_bits +: l2_index_bits];
    assign tag   = mem_address[l2_addr_bits-1 -: l2_tag_bits];

    // lru bit names the victim way of each set
    assign victim = lru_bits[index];

    // strobes go to the victim on a miss, to the hit way otherwise
    assign sel_way = way_sel_method ? victim : way1_hit;

    // fill data or upstream write data
    assign line_in = line_datain_sel ? mem_wdata : pmem_rdata;

    l2_way way0_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (index),
        .tag        (tag),
        .load_line  (load_line_data && !sel_way),
        .load_valid (load_valid && !sel_way),
        .load_dirty (load_dirty && !sel_way),
        .valid_in   (valid_in),
        .dirty_in   (dirty_in),
        .line_in    (line_in),
        .way_hit    (way0_hit),
        .way_dirty  (way0_dirty),
        .way_tag    (way0_tag),
        .way_line   (way0_line)
    );

    l2_way way1_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (index),
        .tag        (tag),
        .load_line  (load_line_data && sel_way),
        .load_valid (load_valid && sel_way),
        .load_dirty (load_dirty && sel_way),
        .valid_in   (valid_in),
        .dirty_in   (dirty_in),
        .line_in    (line_in),
        .way_hit    (way1_hit),
        .way_dirty  (way1_dirty),
        .way_tag    (way1_tag),
        .way_line   (way1_line)
    );

    // point at the way that did not hit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (load_lru) begin
            lru_bits[index] <= way0_hit;
        end
    end

    // results combined
    assign hit       = way0_hit || way1_hit;
    assign dirty     = victim ? way1_dirty : way0_dirty;
    assign mem_rdata = way1_hit ? way1_line : way0_line;

    // write-back data always comes from the victim
    assign pmem_wdata = victim ? way1_line : way0_line;

    // victim line address for write-back, request line otherwise
    assign pmem_address = address_sel ?
        {(victim ? way1_tag : way0_tag), index, {l2_offset_bits{1'b0}}} :
        {tag, index, {l2_offset_bits{1'b0}}};

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (!rst_n)
        !(way0_hit && way1_hit));

endmodule

//--- logic/l2_cache.sv
`timescale 1ns/100ps

module l2_cache (
    input  logic                   clk,
    input  logic                   rst_n,
    // upstream cache port
    input  l2_cache_pkg::l2_addr_t mem_address,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  l2_cache_pkg::l2_line_t mem_wdata,
    output l2_cache_pkg::l2_line_t mem_rdata,
    output logic                   mem_resp,
    // physical memory port
    output l2_cache_pkg::l2_addr_t pmem_address,
    output l2_cache_pkg::l2_line_t pmem_wdata,
    input  l2_cache_pkg::l2_line_t pmem_rdata,
    output logic                   pmem_read,
    output logic                   pmem_write,
    input  logic                   pmem_resp,
    // high during write-back and fill
    output logic                   if_miss
);

    // control to datapath
    logic load_line_data;
    logic load_valid;
    logic load_dirty;
    logic load_lru;
    logic line_datain_sel;
    logic valid_in;
    logic dirty_in;
    logic way_sel_method;
    logic address_sel;

    // datapath to control
    logic hit;
    logic dirty;

    l2_cache_control control_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_resp        (mem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_resp       (pmem_resp),
        .hit             (hit),
        .dirty           (dirty),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .way_sel_method  (way_sel_method),
        .address_sel     (address_sel),
        .if_miss         (if_miss)
    );

    l2_datapath datapath_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_wdata      (pmem_wdata),
        .pmem_address    (pmem_address),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .way_sel_method  (way_sel_method),
        .address_sel     (address_sel),
        .hit             (hit),
        .dirty           (dirty)
    );

endmodule

//--- dv/l2_cache_tb.sv
`timescale 1ns/100ps

module l2_cache_tb;

    import l2_cache_pkg::*;

    localparam int clk_period   = 8;
    localparam int directed_ops = 8;
    localparam int rand_ops     = 300;
    localparam int max_latency  = 8;
    localparam bit [31:0] rand_seed = 32'he36b_67d7;

    logic     clk;
    logic     rst_n;
    l2_addr_t mem_address;
    logic     mem_read;
    logic     mem_write;
    l2_line_t mem_wdata;
    l2_line_t mem_rdata;
    logic     mem_resp;
    l2_addr_t pmem_address;
    l2_line_t pmem_wdata;
    l2_line_t pmem_rdata;
    logic     pmem_read;
    logic     pmem_write;
    logic     pmem_resp;
    logic     if_miss;

    // physical memory and upstream view keyed by line address
    l2_line_t pmem_lines [l2_addr_t];
    l2_line_t ref_lines  [l2_addr_t];

    int       data_errs;
    int       proto_errs;
    int       busy_cycles;
    logic     fill_done;
    l2_addr_t last_rd_addr;
    l2_addr_t last_wr_addr;
    l2_line_t last_wr_data;
    l2_line_t rd_data;

    l2_cache dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_resp    (pmem_resp),
        .if_miss      (if_miss)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic l2_addr_t line_of(input l2_addr_t addr);
        return {addr[l2_addr_bits-1:l2_offset_bits], {l2_offset_bits{1'b0}}};
    endfunction

    // never-written line where each word mixes the whole address
    function automatic l2_line_t fill_pattern(input l2_addr_t addr);
        l2_line_t line;
        int       w;
        for (w = 0; w < 8; w++) begin
            line[w*32 +: 32] = addr ^ (32'h9e37_79b9 * (w + 1)) ^ {addr[15:0], addr[31:16]};
        end
        return line;
    endfunction

    // what upstream should read back
    function automatic l2_line_t expected_line(input l2_addr_t addr);
        if (ref_lines.exists(line_of(addr))) begin
            return ref_lines[line_of(addr)];
        end
        return fill_pattern(line_of(addr));
    endfunction

    function automatic l2_line_t stored_line(input l2_addr_t addr);
        if (pmem_lines.exists(addr)) begin
            return pmem_lines[addr];
        end
        return fill_pattern(addr);
    endfunction

    function automatic l2_line_t random_line();
        l2_line_t line;
        int       w;
        for (w = 0; w < 8; w++) begin
            line[w*32 +: 32] = $urandom();
        end
        return line;
    endfunction

    // one upstream request held until mem_resp
    task automatic access(input string test, input bit write, input l2_addr_t addr,
                          input l2_line_t wdata);
        l2_line_t exp;
        @(posedge clk);
        mem_address <= addr;
        mem_read    <= !write;
        mem_write   <= write;
        mem_wdata   <= wdata;
        @(posedge clk);
        while (!mem_resp) begin
            @(posedge clk);
        end
        exp = expected_line(addr);
        if (write) begin
            ref_lines[line_of(addr)] = wdata;
        end else begin
            rd_data = mem_rdata;
            assert (mem_rdata == exp) else begin
                data_errs++;
                $display("ERR %s: expected %h actual %h", test, exp, mem_rdata);
            end
        end
        // drop on the edge that saw mem_resp
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    // physical memory answering each strobe after 1 to 8 cycles
    initial begin
        int       delay;
        l2_addr_t addr;
        pmem_resp  <= 1'b0;
        pmem_rdata <= '0;
        forever begin
            @(posedge clk);
            if (pmem_read || pmem_write) begin
                addr  = pmem_address;
                delay = $urandom_range(max_latency, 1);
                repeat (delay - 1) @(posedge clk);
                if (pmem_write) begin
                    last_wr_addr = addr;
                    last_wr_data = pmem_wdata;
                    pmem_lines[addr] = pmem_wdata;
                    // written-back line must hold the latest upstream data
                    assert (pmem_lines[addr] == expected_line(addr)) else begin
                        data_errs++;
                        $display("ERR write_back: expected %h actual %h",
                                 expected_line(addr), pmem_lines[addr]);
                    end
                end else begin
                    last_rd_addr = addr;
                    pmem_rdata <= stored_line(addr);
                end
                pmem_resp <= 1'b1;
                @(posedge clk);
                pmem_resp <= 1'b0;
            end
        end
    end

    // downstream protocol checked on every edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (pmem_read || pmem_write) begin
                busy_cycles++;
            end
            assert (!(pmem_read && pmem_write)) else begin
                proto_errs++;
                $display("pmem_read and pmem_write are high together at %0t", $time);
            end
            assert (!(pmem_read || pmem_write) || pmem_address[l2_offset_bits-1:0] == '0)
            else begin
                proto_errs++;
                $display("pmem_address is not line aligned at %0t", $time);
            end
            // if_miss high during write-back and in the cycle after a fill
            assert (if_miss == (pmem_write || fill_done)) else begin
                proto_errs++;
                $display("ERR if_miss: expected %b actual %b",
                         pmem_write || fill_done, if_miss);
            end
            fill_done = pmem_read && pmem_resp;
        end
    end

    // watchdog allowing 64 cycles per operation
    initial begin
        repeat ((directed_ops + rand_ops) * 64) @(posedge clk);
        $display("timeout: the cache stopped answering requests");
        $display("Regression failed");
        $finish;
    end

    initial begin
        l2_addr_t addr_a;
        l2_addr_t addr;
        l2_line_t wline;
        int       busy_before;
        int       i;
        bit       op_write;
        void'($urandom(rand_seed));
        clk         = 1'b0;
        rst_n       <= 1'b0;
        mem_address <= '0;
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        mem_wdata   <= '0;
        data_errs   = 0;
        proto_errs  = 0;
        busy_cycles = 0;
        fill_done   = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // quiet outputs before any request
        assert (!mem_resp && !pmem_read && !pmem_write && !if_miss) else begin
            proto_errs++;
            $display("outputs are not idle after reset");
        end

        // read miss then hit in set 1
        addr_a = 32'h0000_1024;
        access("read_miss", 1'b0, addr_a, '0);
        assert (last_rd_addr == line_of(addr_a)) else begin
            data_errs++;
            $display("ERR read_miss: expected %h actual %h", line_of(addr_a), last_rd_addr);
        end
        busy_before = busy_cycles;
        access("read_hit", 1'b0, addr_a, '0);
        assert (busy_cycles == busy_before) else begin
            proto_errs++;
            $display("repeat read went to memory");
        end

        // write hit and read back without memory traffic
        wline = random_line();
        busy_before = busy_cycles;
        access("write_hit", 1'b1, addr_a, wline);
        access("write_read", 1'b0, addr_a, '0);
        assert (rd_data == wline) else begin
            data_errs++;
            $display("ERR write_read: expected %h actual %h", wline, rd_data);
        end
        assert (busy_cycles == busy_before) else begin
            proto_errs++;
            $display("write hit or its read back went to memory");
        end

        // dirty A in set 2 is the LRU victim at the third tag
        addr_a = 32'h0000_3040;
        wline  = random_line();
        access("evict_write", 1'b1, addr_a, wline);
        access("evict_fill_b", 1'b0, 32'h0000_5040, '0);
        access("evict_fill_c", 1'b0, 32'h0000_7040, '0);
        assert (last_wr_addr == line_of(addr_a)) else begin
            data_errs++;
            $display("ERR evict_addr: expected %h actual %h", line_of(addr_a), last_wr_addr);
        end
        assert (last_wr_data == wline) else begin
            data_errs++;
            $display("ERR evict_data: expected %h actual %h", wline, last_wr_data);
        end

        // three tags per set force evictions
        for (i = 0; i < rand_ops; i++) begin
            op_write = ($urandom_range(1, 0) == 32'd1);
            addr = {l2_tag_t'(24'h00_0100 + $urandom_range(2, 0)),
                    l2_index_t'($urandom_range(7, 0)),
                    5'($urandom_range(31, 0))};
            access("random", op_write, addr, random_line());
        end

        @(posedge clk);
        $display("errors: data %0d protocol %0d", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- l2_cache.f
logic/l2_cache_pkg.sv
logic/l2_way.sv
logic/l2_cache_control.sv
logic/l2_datapath.sv
logic/l2_cache.sv
dv/l2_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the l2 cache testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module l2_cache_tb -f l2_cache.f -o l2_cache_sim &&
    ./obj_dir/l2_cache_sim > sim.log 2>&1

cat sim.log 2>/dev/null

# pass only if the log holds the pass message
grep -qx "Regression passed" sim.log && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
